//--- bsrDecOp.sv
// BSR instruction decoder top level.
// Classifies a strobed word, routes its operands and formats the
// immediate, then registers the result for one cycle of latency.
`timescale 1ns/1ns
`default_nettype none

module bsrDecOp #(
	parameter int ImmWidth = 32
) (
	input wire clock,
	input wire rst,
	input wire bsrDecPkg::instrT istrWord,
	input wire istrValid,
	output bsrDecPkg::regIdT idRegN,
	output bsrDecPkg::regIdT idRegM,
	output logic [ImmWidth-1:0] idImm,
	output bsrDecPkg::ucmdT idUCmd,
	output logic [7:0] idUIxt,
	output logic idValid
);
	import bsrDecPkg::*;

	ucmdT ucmd;
	fmidT fmid;
	btyT bty;
	ucmdT ixSub;
	regIdT regN;
	regIdT regM;
	logic [ImmWidth-1:0] imm;
	logic [7:0] uixt;

	bsrOpClassify classify_i (
		.istrWord(istrWord),
		.ucmd(ucmd),
		.fmid(fmid),
		.bty(bty),
		.ixSub(ixSub)
	);

	bsrOperandRoute route_i (
		.istrWord(istrWord),
		.fmid(fmid),
		.regN(regN),
		.regM(regM)
	);

	bsrImmFormat #(
		.ImmWidth(ImmWidth)
	) immFmt_i (
		.istrWord(istrWord),
		.fmid(fmid),
		.bty(bty),
		.ixSub(ixSub),
		.imm(imm),
		.uixt(uixt)
	);

	always_ff @(posedge clock) begin
		if (rst) begin
			idValid <= 1'b0;
			idUCmd <= UCMD_INVOP;
			idRegN <= REG_ZZR;
			idRegM <= REG_ZZR;
			idImm <= '0;
			idUIxt <= 8'h00;
		end else begin
			idValid <= istrValid;	// High for one cycle per strobe.
			if (istrValid) begin
				idUCmd <= ucmd;
				idRegN <= regN;
				idRegM <= regM;
				idImm <= imm;
				idUIxt <= uixt;
			end
		end
	end

endmodule

`default_nettype wire

//--- bsrDecOpTb.sv
// Testbench for the BSR decoder top level.
// Drives directed and LFSR words and checks every result against a
// reference decode built from the opcode rules.
`timescale 1ns/1ns
`default_nettype none

module bsrDecOpTb;
	import bsrDecPkg::*;

	localparam int ImmWidth = 32;
	localparam int NumDirected = 45;
	localparam int NumRandom = 400;
	localparam logic [15:0] dirWords [0:NumDirected-1] = '{
		16'h0012, 16'h0345, 16'h0467, 16'h07AB, 16'h0B12, 16'h0FFE, 16'h1012, 16'h18AB,
		16'h1A00, 16'h1B11, 16'h1FCD, 16'h2080, 16'h237F, 16'h24F0, 16'h25F0, 16'h2612,
		16'h2700, 16'h2835, 16'h2BF9, 16'h2C05, 16'h2DF3, 16'h2F0A, 16'h3000, 16'h3010,
		16'h30C0, 16'h30A0, 16'h3002, 16'h3032, 16'h3042, 16'h3074, 16'h30F7, 16'h3058,
		16'h306B, 16'h30AC, 16'h30EF, 16'h3001, 16'h3100, 16'h4000, 16'h8123, 16'hA800,
		16'hB123, 16'hC080, 16'hE17F, 16'hD000, 16'hF000
	};

	logic clock = 1'b0;
	logic rst;
	instrT istrWord;
	logic istrValid;
	regIdT idRegN;
	regIdT idRegM;
	logic [ImmWidth-1:0] idImm;
	ucmdT idUCmd;
	logic [7:0] idUIxt;
	logic idValid;

	logic [15:0] lfsrState = 16'd53566;
	logic expValid;
	logic checkFields;
	ucmdT expUCmd;
	regIdT expRegN;
	regIdT expRegM;
	logic [ImmWidth-1:0] expImm;
	logic [7:0] expUIxt;

	bsrDecOp #(.ImmWidth(ImmWidth)) dut_i (.*);

	always #5 clock = ~clock;

	function automatic logic [15:0] takeBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
		end
		return v;
	endfunction

	task automatic failRun();
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		failRun();
	endtask

	// Reference decode of one word from the opcode group rules.
	task automatic refDecode(input logic [15:0] w);
		logic [3:0] op;
		logic [3:0] lo;
		logic ld;
		btyT sz;
		regIdT n;
		n = {2'b00, w[7:4]};
		op = w[11:8];
		lo = w[3:0];
		expUCmd = UCMD_INVOP;
		expRegN = REG_ZZR;
		expRegM = REG_ZZR;
		expImm = '0;
		expUIxt = 8'h00;
		if (w[15:12] == 4'h0 || (w[15:8] == 8'h30 && lo >= 4'h4 && lo[3:2] != 2'b10)) begin
			if (w[15:12] != 4'h0)
				op = lo;	// PC form reuses the indexed size layout.
			ld = (op[1:0] == 2'd3) || op[3];
			sz = (op[1:0] == 2'd3) ? (op[3] ? BTY_UW : BTY_UB) : {1'b0, op[1:0]};
			if (!ld)
				expUCmd = UCMD_MOVB_RM + op[1:0];
			else if (op[1:0] == 2'd3)
				expUCmd = op[3] ? UCMD_MOVUW_MR : UCMD_MOVUB_MR;
			else
				expUCmd = UCMD_MOVB_MR + op[1:0];
			if (w[15:12] == 4'h0) begin
				expRegN = n;
				expRegM = {2'b00, w[3:0]};
				expUIxt = {op[2] ? IXT_RDL : IXT_REG, ld, sz};
			end else begin
				expRegN = ld ? n : REG_PC;
				expRegM = ld ? REG_PC : n;
				expUIxt = {IXT_RDL, ld, sz};
			end
		end else if (w[15:12] == 4'h1) begin
			case (op)
				4'h0: expUCmd = UCMD_ALU_ADD;
				4'h1: expUCmd = UCMD_ALU_SUB;
				4'h2: expUCmd = UCMD_ALU_ADC;
				4'h3: expUCmd = UCMD_ALU_SBB;
				4'h4: expUCmd = UCMD_ALU_TST;
				4'h5: expUCmd = UCMD_ALU_AND;
				4'h6: expUCmd = UCMD_ALU_OR;
				4'h7: expUCmd = UCMD_ALU_XOR;
				4'h8: expUCmd = UCMD_MOV_RR;
				4'h9: expUCmd = UCMD_ALU_MULS;
				4'hC: expUCmd = UCMD_ALU_CMPEQ;
				4'hD: expUCmd = UCMD_ALU_CMPHI;
				4'hE: expUCmd = UCMD_ALU_CMPGT;
				4'hF: expUCmd = UCMD_ALU_MULU;
				default: expUCmd = UCMD_INVOP;
			endcase
			if (expUCmd != UCMD_INVOP) begin
				expRegN = n;
				expRegM = {2'b00, w[3:0]};
			end
		end else if (w[15:12] == 4'h2) begin
			case (op[3:2])
				2'd0: begin
					expUCmd = UCMD_CF_BRA + op[1:0];
					expRegN = REG_DLR;
					expRegM = REG_PC;
					expImm = {{(ImmWidth-8){w[7]}}, w[7:0]};
					expUIxt = {IXT_RDI, 1'b1, BTY_SW};
				end
				2'd1: if (op[1:0] != 2'd3) begin
					expUCmd = (op[1:0] == 2'd2) ? UCMD_ALU_LDISH : UCMD_ALU_LDIX;
					expRegN = REG_DLR;
					expRegM = REG_IMM;
					expImm = {{(ImmWidth-8){op[1:0] == 2'd1}}, w[7:0]};
				end
				2'd2: begin
					ld = op[1];
					sz = op[0] ? BTY_SW : BTY_SL;
					if (ld)
						expUCmd = op[0] ? UCMD_MOVW_MR : UCMD_MOVL_MR;
					else
						expUCmd = op[0] ? UCMD_MOVW_RM : UCMD_MOVL_RM;
					expRegN = ld ? n : REG_SP;
					expRegM = ld ? REG_SP : n;
					expImm = {{(ImmWidth-4){1'b0}}, w[3:0]};
					expUIxt = {IXT_RDI, ld, sz};
				end
				default: begin
					expUCmd = (op[1:0] == 2'd3) ? UCMD_ALU_CMPGE :
						(op[1:0] == 2'd2) ? UCMD_ALU_CMPGT : UCMD_ALU_CMPEQ;
					expRegN = n;
					expRegM = REG_IMM;
					expImm = {{(ImmWidth-4){op[1:0] == 2'd1}}, w[3:0]};
				end
			endcase
		end else if (w[15:8] == 8'h30) begin
			if (lo == 4'h0 && w[7:4] == 4'h0) begin
				expUCmd = UCMD_NOP;
			end else if (lo == 4'h0 && (w[7:4] <= 4'h9 || w[7:4] == 4'hC)) begin
				expUCmd = UCMD_OP_IXT;
				expUIxt = {4'h0, w[7:4]};
			end else if (lo == 4'h2 && w[7:4] <= 4'h3) begin
				expUCmd = UCMD_CF_BRA + w[5:4];
				expRegN = REG_DLR;
				expRegM = REG_PC;
				expUIxt = {IXT_RDL, 1'b1, BTY_SW};
			end else if (lo[3:2] == 2'b10) begin
				expUCmd = UCMD_MOV_PUSH + lo[1:0];
				expRegN = n;
			end
		end else if (w[15:12] == 4'hA || w[15:12] == 4'hB) begin
			expUCmd = UCMD_ALU_LDIX;
			expRegN = REG_DLR;
			expRegM = REG_IMM;
			expImm = {{(ImmWidth-12){w[12]}}, w[11:0]};	// 0xB pads with ones.
		end else if (w[15:12] == 4'hC || w[15:12] == 4'hE) begin
			expUCmd = w[13] ? UCMD_MOV_IR : UCMD_ALU_ADD;
			expRegN = {2'b00, op};
			expRegM = REG_IMM;
			expImm = {{(ImmWidth-8){w[7]}}, w[7:0]};
		end
	endtask

	task automatic checkOutputs();
		if (dut_i.props_i.failed) begin
			$display("ERROR at %0t ns: a bound decoder property failed", $time);
			failRun();
		end
		assert (idValid === expValid) else reportMismatch("idValid", expValid, idValid);
		if (checkFields) begin
			assert (idUCmd === expUCmd) else reportMismatch("idUCmd", expUCmd, idUCmd);
			assert (idRegN === expRegN) else reportMismatch("idRegN", expRegN, idRegN);
			assert (idRegM === expRegM) else reportMismatch("idRegM", expRegM, idRegM);
			assert (idImm === expImm) else reportMismatch("idImm", expImm, idImm);
			assert (idUIxt === expUIxt) else reportMismatch("idUIxt", expUIxt, idUIxt);
		end
	endtask

	// Checks the previous result, then presents the next word.
	task automatic applyWord(input logic [15:0] w, input logic strobe);
		@(negedge clock);
		checkOutputs();
		istrWord = w;
		istrValid = strobe;
		expValid = strobe;
		checkFields = strobe;
		if (strobe)
			refDecode(w);
	endtask

	initial begin : watchdog
		for (int i = 0; i < 20000; i++)
			@(posedge clock);
		$display("ERROR: timeout, the stimulus did not finish within 20000 cycles");
		failRun();
	end

	initial begin
		logic [15:0] w;
		logic [15:0] gap;
		rst = 1'b1;
		istrWord = '0;
		istrValid = 1'b0;
		expValid = 1'b0;
		checkFields = 1'b1;
		expUCmd = UCMD_INVOP;
		expRegN = REG_ZZR;
		expRegM = REG_ZZR;
		expImm = '0;
		expUIxt = 8'h00;
		@(posedge clock);
		for (int i = 0; i < 4; i++) begin
			@(negedge clock);
			checkOutputs();
		end
		rst = 1'b0;
		for (int i = 0; i < NumDirected; i++)
			applyWord(dirWords[i], 1'b1);
		for (int i = 0; i < NumRandom; i++) begin
			gap = takeBits(2);
			if (gap[1:0] == 2'd0)
				applyWord(16'h0000, 1'b0);	// Idle cycle between words.
			w = takeBits(16);
			applyWord(w, 1'b1);
		end
		applyWord(16'h0000, 1'b0);
		for (int i = 0; i < 8 && idValid; i++)
			@(negedge clock);
		if (idValid) begin
			$display("ERROR: timeout, idValid did not return low after the last word");
			failRun();
		end
		if (dut_i.props_i.failed) begin
			$display("ERROR: a bound decoder property failed");
			$display("SIMULATION FAILED");
			$fatal(1);
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- bsrDecOp_properties.sv
// Bound checker for the BSR decoder top level.
// Covers reset values, the one-cycle valid timing and the invalid and
// system op output shapes.
`timescale 1ns/1ns
`default_nettype none

module bsrDecOp_properties #(
	parameter int ImmWidth = 32
) (
	input wire clock,
	input wire rst,
	input wire istrValid,
	input wire idValid,
	input wire bsrDecPkg::ucmdT idUCmd,
	input wire bsrDecPkg::regIdT idRegN,
	input wire bsrDecPkg::regIdT idRegM,
	input wire [ImmWidth-1:0] idImm,
	input wire [7:0] idUIxt
);
	import bsrDecPkg::*;

	logic failed = 1'b0;	// Raised by any failing property below.

	resetValues: assert property (@(posedge clock) rst |=> (!idValid && idUCmd == UCMD_INVOP
		&& idRegN == REG_ZZR && idRegM == REG_ZZR && idImm == '0 && idUIxt == 8'h00))
	else begin
		failed = 1'b1;
		$error("outputs left their reset values while reset was applied");
	end

	validFollows: assert property (@(posedge clock) disable iff (rst) istrValid |=> idValid)
	else begin
		failed = 1'b1;
		$error("idValid missing one cycle after a strobe");
	end

	validQuiet: assert property (@(posedge clock) disable iff (rst) !istrValid |=> !idValid)
	else begin
		failed = 1'b1;
		$error("idValid raised without a strobe");
	end

	// An invalid word carries no operands at all.
	invalidShape: assert property (@(posedge clock) disable iff (rst)
		(idValid && idUCmd == UCMD_INVOP) |-> (idRegN == REG_ZZR && idRegM == REG_ZZR
		&& idImm == '0 && idUIxt == 8'h00))
	else begin
		failed = 1'b1;
		$error("INVOP result carries operands");
	end

	sysShape: assert property (@(posedge clock) disable iff (rst)
		(idValid && idUCmd == UCMD_OP_IXT) |-> (idRegN == REG_ZZR && idRegM == REG_ZZR
		&& idImm == '0 && idUIxt != 8'h00))
	else begin
		failed = 1'b1;
		$error("system op result has operands or no subcode");
	end

endmodule

bind bsrDecOp bsrDecOp_properties #(.ImmWidth(ImmWidth)) props_i (.*);

`default_nettype wire

//--- bsrDecPkg.sv
// BSR decoder package.
// Shared word, register, micro-command, operand form and size encodings
// used by every stage of the instruction decoder.
`default_nettype none

package bsrDecPkg;

	typedef logic [15:0] instrT;
	typedef logic [5:0] regIdT;
	typedef logic [7:0] ucmdT;
	typedef logic [4:0] fmidT;
	typedef logic [2:0] btyT;
	typedef logic [3:0] ixtKindT;

	// Special registers sit above the 16 general registers.
	parameter regIdT REG_DLR = 6'h10;	// Scratch destination.
	parameter regIdT REG_SP  = 6'h11;
	parameter regIdT REG_PC  = 6'h12;
	parameter regIdT REG_IMM = 6'h1E;	// Operand comes from the immediate.
	parameter regIdT REG_ZZR = 6'h1F;	// Reads as zero.

	// Micro-commands.
	parameter ucmdT UCMD_NOP      = 8'h00;
	parameter ucmdT UCMD_MOVB_RM  = 8'h01;
	parameter ucmdT UCMD_MOVW_RM  = 8'h02;
	parameter ucmdT UCMD_MOVL_RM  = 8'h03;
	parameter ucmdT UCMD_MOVUB_RM = 8'h04;
	parameter ucmdT UCMD_MOVUW_RM = 8'h05;
	parameter ucmdT UCMD_MOVB_MR  = 8'h09;
	parameter ucmdT UCMD_MOVW_MR  = 8'h0A;
	parameter ucmdT UCMD_MOVL_MR  = 8'h0B;
	parameter ucmdT UCMD_MOVUB_MR = 8'h0C;
	parameter ucmdT UCMD_MOVUW_MR = 8'h0D;
	parameter ucmdT UCMD_ALU_ADD   = 8'h10;
	parameter ucmdT UCMD_ALU_SUB   = 8'h11;
	parameter ucmdT UCMD_ALU_ADC   = 8'h12;
	parameter ucmdT UCMD_ALU_SBB   = 8'h13;
	parameter ucmdT UCMD_ALU_TST   = 8'h14;
	parameter ucmdT UCMD_ALU_AND   = 8'h15;
	parameter ucmdT UCMD_ALU_OR    = 8'h16;
	parameter ucmdT UCMD_ALU_XOR   = 8'h17;
	parameter ucmdT UCMD_ALU_MULS  = 8'h18;
	parameter ucmdT UCMD_ALU_MULU  = 8'h19;
	parameter ucmdT UCMD_ALU_CMPEQ = 8'h1A;
	parameter ucmdT UCMD_ALU_CMPHI = 8'h1B;
	parameter ucmdT UCMD_ALU_CMPGT = 8'h1C;
	parameter ucmdT UCMD_ALU_CMPGE = 8'h1D;
	parameter ucmdT UCMD_ALU_LDIX  = 8'h1E;
	parameter ucmdT UCMD_ALU_LDISH = 8'h1F;
	parameter ucmdT UCMD_MOV_RR    = 8'h20;
	parameter ucmdT UCMD_MOV_IR    = 8'h21;
	parameter ucmdT UCMD_MOV_PUSH  = 8'h22;
	parameter ucmdT UCMD_MOV_PUSHC = 8'h23;
	parameter ucmdT UCMD_MOV_POP   = 8'h24;
	parameter ucmdT UCMD_MOV_POPC  = 8'h25;
	parameter ucmdT UCMD_CF_BRA = 8'h30;
	parameter ucmdT UCMD_CF_BSR = 8'h31;
	parameter ucmdT UCMD_CF_BT  = 8'h32;
	parameter ucmdT UCMD_CF_BF  = 8'h33;
	parameter ucmdT UCMD_OP_IXT = 8'h3E;	// System op whose subcode rides in the extension byte.
	parameter ucmdT UCMD_INVOP  = 8'h3F;

	// System op subcodes.
	parameter ucmdT IX_NONE  = 8'h00;
	parameter ucmdT IX_RTS   = 8'h01;
	parameter ucmdT IX_SLEEP = 8'h02;
	parameter ucmdT IX_BREAK = 8'h03;
	parameter ucmdT IX_CLRT  = 8'h04;
	parameter ucmdT IX_SETT  = 8'h05;
	parameter ucmdT IX_CLRS  = 8'h06;
	parameter ucmdT IX_SETS  = 8'h07;
	parameter ucmdT IX_NOTT  = 8'h08;
	parameter ucmdT IX_NOTS  = 8'h09;
	parameter ucmdT IX_RTE   = 8'h0C;

	// Operand forms.
	parameter fmidT FMID_INV        = 5'd0;
	parameter fmidT FMID_Z          = 5'd1;
	parameter fmidT FMID_REG        = 5'd2;
	parameter fmidT FMID_REGREG     = 5'd3;
	parameter fmidT FMID_IMM8REG    = 5'd4;
	parameter fmidT FMID_IMM8Z      = 5'd5;
	parameter fmidT FMID_IMM8N      = 5'd6;
	parameter fmidT FMID_REGSTREG   = 5'd7;
	parameter fmidT FMID_LDREGREG   = 5'd8;
	parameter fmidT FMID_REGSTDRREG = 5'd9;
	parameter fmidT FMID_LDDRREGREG = 5'd10;
	parameter fmidT FMID_REGSTDRPC  = 5'd11;
	parameter fmidT FMID_LDDRPCREG  = 5'd12;
	parameter fmidT FMID_IMM4ZREG   = 5'd13;
	parameter fmidT FMID_IMM4NREG   = 5'd14;
	parameter fmidT FMID_DRPC       = 5'd15;
	parameter fmidT FMID_PCDISP8    = 5'd16;
	parameter fmidT FMID_IMM12Z     = 5'd17;
	parameter fmidT FMID_IMM12N     = 5'd18;
	parameter fmidT FMID_REGSTDI4SP = 5'd19;
	parameter fmidT FMID_LDDI4SPREG = 5'd20;

	// Access sizes. Bit 2 is set for the unsigned loads.
	parameter btyT BTY_SB = 3'd0;
	parameter btyT BTY_SW = 3'd1;
	parameter btyT BTY_SL = 3'd2;
	parameter btyT BTY_UB = 3'd4;
	parameter btyT BTY_UW = 3'd5;

	// Addressing kinds in the top nibble of the extension byte.
	parameter ixtKindT IXT_REG = 4'd0;	// Base plus scaled index register.
	parameter ixtKindT IXT_RDL = 4'd1;	// Base plus scaled DLR.
	parameter ixtKindT IXT_RDI = 4'd2;	// Base plus scaled immediate.

endpackage

`default_nettype wire

//--- bsrImmFormat.sv
// Immediate formatter for the BSR decoder.
// Extends the immediate field to ImmWidth bits and packs the extension
// byte from addressing kind, load flag and access size.
`timescale 1ns/1ns
`default_nettype none

module bsrImmFormat #(
	parameter int ImmWidth = 32
) (
	input wire bsrDecPkg::instrT istrWord,
	input wire bsrDecPkg::fmidT fmid,
	input wire bsrDecPkg::btyT bty,
	input wire bsrDecPkg::ucmdT ixSub,
	output logic [ImmWidth-1:0] imm,
	output logic [7:0] uixt
);
	import bsrDecPkg::*;

	ixtKindT kind;
	logic isLoad;
	logic hasIxt;

	always_comb begin
		case (fmid)
			FMID_IMM8REG, FMID_PCDISP8:
				imm = {{(ImmWidth-8){istrWord[7]}}, istrWord[7:0]};
			FMID_IMM8Z:
				imm = {{(ImmWidth-8){1'b0}}, istrWord[7:0]};
			FMID_IMM8N:
				imm = {{(ImmWidth-8){1'b1}}, istrWord[7:0]};
			FMID_IMM12Z:
				imm = {{(ImmWidth-12){1'b0}}, istrWord[11:0]};
			FMID_IMM12N:
				imm = {{(ImmWidth-12){1'b1}}, istrWord[11:0]};
			FMID_IMM4ZREG, FMID_REGSTDI4SP, FMID_LDDI4SPREG:
				imm = {{(ImmWidth-4){1'b0}}, istrWord[3:0]};
			FMID_IMM4NREG:
				imm = {{(ImmWidth-4){1'b1}}, istrWord[3:0]};
			default:
				imm = '0;
		endcase
	end

	always_comb begin
		kind = IXT_REG;
		isLoad = 1'b0;
		hasIxt = 1'b1;
		case (fmid)
			FMID_REGSTREG: kind = IXT_REG;
			FMID_LDREGREG: begin
				kind = IXT_REG;
				isLoad = 1'b1;
			end
			FMID_REGSTDRREG, FMID_REGSTDRPC: kind = IXT_RDL;
			FMID_LDDRREGREG, FMID_LDDRPCREG, FMID_DRPC: begin
				kind = IXT_RDL;
				isLoad = 1'b1;
			end
			FMID_REGSTDI4SP: kind = IXT_RDI;
			FMID_PCDISP8, FMID_LDDI4SPREG: begin
				kind = IXT_RDI;
				isLoad = 1'b1;	// Branches count as loads of the target.
			end
			default: hasIxt = 1'b0;
		endcase
	end

	// System forms carry their subcode instead of an addressing mode.
	assign uixt = (fmid == FMID_Z || fmid == FMID_REG) ? ixSub :
		hasIxt ? {kind, isLoad, bty} : 8'h00;

endmodule

`default_nettype wire

//--- bsrOpClassify.sv
// Opcode classifier for the BSR decoder.
// Maps an instruction word to its micro-command, operand form,
// access size and system subcode.
`timescale 1ns/1ns
`default_nettype none

module bsrOpClassify (
	input wire bsrDecPkg::instrT istrWord,
	output bsrDecPkg::ucmdT ucmd,
	output bsrDecPkg::fmidT fmid,
	output bsrDecPkg::btyT bty,
	output bsrDecPkg::ucmdT ixSub
);
	import bsrDecPkg::*;

	logic [23:0] row;	// {ucmd, fmid, bty, ixSub}.

	function automatic logic [23:0] ent(ucmdT u, fmidT f, btyT b);
		return {u, f, b, IX_NONE};
	endfunction

	function automatic logic [23:0] sysOp(ucmdT ix);
		return {UCMD_OP_IXT, FMID_Z, BTY_SB, ix};
	endfunction

	always_comb begin
		casez (istrWord)
			// Register indexed stores and loads.
			16'h00??: row = ent(UCMD_MOVB_RM, FMID_REGSTREG, BTY_SB);
			16'h01??: row = ent(UCMD_MOVW_RM, FMID_REGSTREG, BTY_SW);
			16'h02??: row = ent(UCMD_MOVL_RM, FMID_REGSTREG, BTY_SL);
			16'h03??: row = ent(UCMD_MOVUB_MR, FMID_LDREGREG, BTY_UB);
			16'h04??: row = ent(UCMD_MOVB_RM, FMID_REGSTDRREG, BTY_SB);
			16'h05??: row = ent(UCMD_MOVW_RM, FMID_REGSTDRREG, BTY_SW);
			16'h06??: row = ent(UCMD_MOVL_RM, FMID_REGSTDRREG, BTY_SL);
			16'h07??: row = ent(UCMD_MOVUB_MR, FMID_LDDRREGREG, BTY_UB);
			16'h08??: row = ent(UCMD_MOVB_MR, FMID_LDREGREG, BTY_SB);
			16'h09??: row = ent(UCMD_MOVW_MR, FMID_LDREGREG, BTY_SW);
			16'h0A??: row = ent(UCMD_MOVL_MR, FMID_LDREGREG, BTY_SL);
			16'h0B??: row = ent(UCMD_MOVUW_MR, FMID_LDREGREG, BTY_UW);
			16'h0C??: row = ent(UCMD_MOVB_MR, FMID_LDDRREGREG, BTY_SB);
			16'h0D??: row = ent(UCMD_MOVW_MR, FMID_LDDRREGREG, BTY_SW);
			16'h0E??: row = ent(UCMD_MOVL_MR, FMID_LDDRREGREG, BTY_SL);
			16'h0F??: row = ent(UCMD_MOVUW_MR, FMID_LDDRREGREG, BTY_UW);

			// Two register ALU ops. 0x1A and 0x1B are unassigned.
			16'h10??: row = ent(UCMD_ALU_ADD, FMID_REGREG, BTY_SB);
			16'h11??: row = ent(UCMD_ALU_SUB, FMID_REGREG, BTY_SB);
			16'h12??: row = ent(UCMD_ALU_ADC, FMID_REGREG, BTY_SB);
			16'h13??: row = ent(UCMD_ALU_SBB, FMID_REGREG, BTY_SB);
			16'h14??: row = ent(UCMD_ALU_TST, FMID_REGREG, BTY_SB);
			16'h15??: row = ent(UCMD_ALU_AND, FMID_REGREG, BTY_SB);
			16'h16??: row = ent(UCMD_ALU_OR, FMID_REGREG, BTY_SB);
			16'h17??: row = ent(UCMD_ALU_XOR, FMID_REGREG, BTY_SB);
			16'h18??: row = ent(UCMD_MOV_RR, FMID_REGREG, BTY_SB);
			16'h19??: row = ent(UCMD_ALU_MULS, FMID_REGREG, BTY_SB);
			16'h1C??: row = ent(UCMD_ALU_CMPEQ, FMID_REGREG, BTY_SB);
			16'h1D??: row = ent(UCMD_ALU_CMPHI, FMID_REGREG, BTY_SB);
			16'h1E??: row = ent(UCMD_ALU_CMPGT, FMID_REGREG, BTY_SB);
			16'h1F??: row = ent(UCMD_ALU_MULU, FMID_REGREG, BTY_SB);

			16'h20??: row = ent(UCMD_CF_BRA, FMID_PCDISP8, BTY_SW);	// Word scaled displacement.
			16'h21??: row = ent(UCMD_CF_BSR, FMID_PCDISP8, BTY_SW);
			16'h22??: row = ent(UCMD_CF_BT, FMID_PCDISP8, BTY_SW);
			16'h23??: row = ent(UCMD_CF_BF, FMID_PCDISP8, BTY_SW);
			16'h24??: row = ent(UCMD_ALU_LDIX, FMID_IMM8Z, BTY_SB);
			16'h25??: row = ent(UCMD_ALU_LDIX, FMID_IMM8N, BTY_SB);
			16'h26??: row = ent(UCMD_ALU_LDISH, FMID_IMM8Z, BTY_SB);
			16'h28??: row = ent(UCMD_MOVL_RM, FMID_REGSTDI4SP, BTY_SL);
			16'h29??: row = ent(UCMD_MOVW_RM, FMID_REGSTDI4SP, BTY_SW);
			16'h2A??: row = ent(UCMD_MOVL_MR, FMID_LDDI4SPREG, BTY_SL);
			16'h2B??: row = ent(UCMD_MOVW_MR, FMID_LDDI4SPREG, BTY_SW);
			16'h2C??: row = ent(UCMD_ALU_CMPEQ, FMID_IMM4ZREG, BTY_SB);
			16'h2D??: row = ent(UCMD_ALU_CMPEQ, FMID_IMM4NREG, BTY_SB);
			16'h2E??: row = ent(UCMD_ALU_CMPGT, FMID_IMM4ZREG, BTY_SB);
			16'h2F??: row = ent(UCMD_ALU_CMPGE, FMID_IMM4ZREG, BTY_SB);

			// Exact system words must be matched ahead of the 0x30zN patterns.
			16'h3000: row = ent(UCMD_NOP, FMID_Z, BTY_SB);
			16'h3010: row = sysOp(IX_RTS);
			16'h3020: row = sysOp(IX_SLEEP);
			16'h3030: row = sysOp(IX_BREAK);
			16'h3040: row = sysOp(IX_CLRT);
			16'h3050: row = sysOp(IX_SETT);
			16'h3060: row = sysOp(IX_CLRS);
			16'h3070: row = sysOp(IX_SETS);
			16'h3080: row = sysOp(IX_NOTT);
			16'h3090: row = sysOp(IX_NOTS);
			16'h30C0: row = sysOp(IX_RTE);
			16'h3002: row = ent(UCMD_CF_BRA, FMID_DRPC, BTY_SW);
			16'h3012: row = ent(UCMD_CF_BSR, FMID_DRPC, BTY_SW);
			16'h3022: row = ent(UCMD_CF_BT, FMID_DRPC, BTY_SW);
			16'h3032: row = ent(UCMD_CF_BF, FMID_DRPC, BTY_SW);

			// PC plus DLR access and the stack ops take their register from bits 7:4.
			16'h30?4: row = ent(UCMD_MOVB_RM, FMID_REGSTDRPC, BTY_SB);
			16'h30?5: row = ent(UCMD_MOVW_RM, FMID_REGSTDRPC, BTY_SW);
			16'h30?6: row = ent(UCMD_MOVL_RM, FMID_REGSTDRPC, BTY_SL);
			16'h30?7: row = ent(UCMD_MOVUB_MR, FMID_LDDRPCREG, BTY_UB);
			16'h30?8: row = ent(UCMD_MOV_PUSH, FMID_REG, BTY_SB);
			16'h30?9: row = ent(UCMD_MOV_PUSHC, FMID_REG, BTY_SB);
			16'h30?A: row = ent(UCMD_MOV_POP, FMID_REG, BTY_SB);
			16'h30?B: row = ent(UCMD_MOV_POPC, FMID_REG, BTY_SB);
			16'h30?C: row = ent(UCMD_MOVB_MR, FMID_LDDRPCREG, BTY_SB);
			16'h30?D: row = ent(UCMD_MOVW_MR, FMID_LDDRPCREG, BTY_SW);
			16'h30?E: row = ent(UCMD_MOVL_MR, FMID_LDDRPCREG, BTY_SL);
			16'h30?F: row = ent(UCMD_MOVUW_MR, FMID_LDDRPCREG, BTY_UW);

			16'hA???: row = ent(UCMD_ALU_LDIX, FMID_IMM12Z, BTY_SB);
			16'hB???: row = ent(UCMD_ALU_LDIX, FMID_IMM12N, BTY_SB);
			16'hC???: row = ent(UCMD_ALU_ADD, FMID_IMM8REG, BTY_SB);	// Rn += simm8.
			16'hE???: row = ent(UCMD_MOV_IR, FMID_IMM8REG, BTY_SB);
			default: row = ent(UCMD_INVOP, FMID_INV, BTY_SB);
		endcase
	end

	assign {ucmd, fmid, bty, ixSub} = row;

endmodule

`default_nettype wire

//--- bsrOperandRoute.sv
// Operand router for the BSR decoder.
// Picks the two register selectors from the operand form and the
// register fields of the instruction word.
`timescale 1ns/1ns
`default_nettype none

module bsrOperandRoute (
	input wire bsrDecPkg::instrT istrWord,
	input wire bsrDecPkg::fmidT fmid,
	output bsrDecPkg::regIdT regN,
	output bsrDecPkg::regIdT regM
);
	import bsrDecPkg::*;

	regIdT fieldO;
	regIdT fieldN;
	regIdT fieldM;

	assign fieldO = {2'b00, istrWord[11:8]};
	assign fieldN = {2'b00, istrWord[7:4]};
	assign fieldM = {2'b00, istrWord[3:0]};

	always_comb begin
		case (fmid)
			FMID_REGREG, FMID_REGSTREG, FMID_LDREGREG,
			FMID_REGSTDRREG, FMID_LDDRREGREG: begin
				regN = fieldN;
				regM = fieldM;
			end
			FMID_IMM8REG: begin
				regN = fieldO;	// Destination sits in the high nibble.
				regM = REG_IMM;
			end
			FMID_IMM8Z, FMID_IMM8N, FMID_IMM12Z, FMID_IMM12N: begin
				regN = REG_DLR;
				regM = REG_IMM;
			end
			FMID_IMM4ZREG, FMID_IMM4NREG: begin
				regN = fieldN;
				regM = REG_IMM;
			end
			FMID_PCDISP8, FMID_DRPC: begin
				regN = REG_DLR;
				regM = REG_PC;
			end
			FMID_REGSTDRPC: begin
				regN = REG_PC;	// Stores put the base on the N side.
				regM = fieldN;
			end
			FMID_LDDRPCREG: begin
				regN = fieldN;
				regM = REG_PC;
			end
			FMID_REGSTDI4SP: begin
				regN = REG_SP;
				regM = fieldN;
			end
			FMID_LDDI4SPREG: begin
				regN = fieldN;
				regM = REG_SP;
			end
			FMID_REG: begin
				regN = fieldN;
				regM = REG_ZZR;
			end
			default: begin
				regN = REG_ZZR;
				regM = REG_ZZR;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- tb.f
bsrDecPkg.sv
bsrOpClassify.sv
bsrOperandRoute.sv
bsrImmFormat.sv
bsrDecOp.sv
bsrDecOp_properties.sv
bsrDecOpTb.sv
